/* sources.f */
verilog/sdram_pkg.sv
verilog/sdram_ifs.sv
verilog/refresh_timer.sv
verilog/bank_row_tracker.sv
verilog/prefetch_buffer.sv
verilog/sdram_pins.sv
verilog/sdram_cmd_seq.sv
verilog/sdram_ctrl_top.sv
bench/sdram_mem_model.sv
bench/sdram_ctrl_sva.sv
bench/tb_sdram_ctrl.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - files:
      - verilog/sdram_pkg.sv
      - verilog/sdram_ifs.sv
      - verilog/refresh_timer.sv
      - verilog/bank_row_tracker.sv
      - verilog/prefetch_buffer.sv
      - verilog/sdram_pins.sv
      - verilog/sdram_cmd_seq.sv
      - verilog/sdram_ctrl_top.sv
  - target: test
    files:
      - bench/sdram_mem_model.sv
      - bench/sdram_ctrl_sva.sv
      - bench/tb_sdram_ctrl.sv

/* bench/tb_sdram_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_ctrl import sdram_pkg::*; ();

    localparam int          T_CAS            = 3;
    localparam int          T_RCD            = 3;
    localparam int          T_RP             = 3;
    localparam int          T_RFC            = 7;
    localparam int          REFRESH_INTERVAL = 750;
    localparam int          PREFETCH_DEPTH   = 8;
    localparam int          TIMEOUT          = 3000;
    localparam int unsigned SEED             = 32'h1e5c_ab82;

    logic        clk;
    logic        rst;
    user_addr_t  user_addr;
    logic        rw;
    word_t       data_in;
    logic        in_valid;
    word_t       data_out;
    logic        busy;
    logic        out_valid;
    logic        sdram_cle;
    logic        sdram_cs;
    logic        sdram_ras;
    logic        sdram_cas;
    logic        sdram_we;
    bank_t       sdram_ba;
    logic [12:0] sdram_a;
    word_t       sdram_dqi;
    word_t       sdram_dqo;
    logic        sdram_dq_oe;
    logic [31:0] read_count;

    word_t ref_mem [user_addr_t];  // reference model, written words only
    word_t exp_q [$];              // expected read data in acceptance order
    int    refresh_gap;
    int    refresh_seen;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    sdram_ctrl_top #(
        .T_CAS            (T_CAS),
        .T_RCD            (T_RCD),
        .T_RP             (T_RP),
        .T_RFC            (T_RFC),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .PREFETCH_DEPTH   (PREFETCH_DEPTH)
    ) u_dut (
        .clk (clk), .rst (rst), .user_addr (user_addr), .rw (rw), .data_in (data_in),
        .in_valid (in_valid), .data_out (data_out), .busy (busy), .out_valid (out_valid),
        .sdram_cle (sdram_cle), .sdram_cs (sdram_cs), .sdram_ras (sdram_ras),
        .sdram_cas (sdram_cas), .sdram_we (sdram_we), .sdram_ba (sdram_ba),
        .sdram_a (sdram_a), .sdram_dqi (sdram_dqi), .sdram_dqo (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

    sdram_mem_model #(.T_CAS(T_CAS)) u_mem (
        .clk (clk), .cs (sdram_cs), .ras (sdram_ras), .cas (sdram_cas), .we (sdram_we),
        .ba (sdram_ba), .a (sdram_a), .dqo (sdram_dqo), .dq_oe (sdram_dq_oe),
        .dqi (sdram_dqi), .read_count (read_count)
    );

    ////////////////////////////////////////////////////////////
    // reporting and reference model
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Error: %s = 0x%08h, expected 0x%08h",
                                    name, got, expected));
        end
    endtask

    function automatic word_t expected_read(input user_addr_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return word_t'(addr);  // never written
    endfunction

    // responses, one per accepted read
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("out_valid pulsed with no read outstanding");
            end else begin
                check("data_out", data_out, exp_q.pop_front());
            end
        end
    end

    // pin protocol assertions from the bound checker
    always @(negedge clk) begin
        if (u_dut.u_sva.fail_count != 0) begin
            stop_on_error("a pin protocol assertion failed");
        end
    end

    // refresh spacing on the pins
    always @(negedge clk) begin
        if (rst) begin
            refresh_gap  <= 0;
            refresh_seen <= 0;
        end else if ({sdram_cs, sdram_ras, sdram_cas, sdram_we} == CMD_REFRESH) begin
            refresh_gap  <= 0;
            refresh_seen <= refresh_seen + 1;
        end else if (refresh_gap > REFRESH_INTERVAL + 100) begin
            stop_on_error("no REFRESH on the pins within the refresh interval");
        end else begin
            refresh_gap <= refresh_gap + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // request driving
    ////////////////////////////////////////////////////////////

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error("busy stayed high, request never taken");
            end
        end
    endtask

    task automatic send(input logic wr, input user_addr_t addr, input word_t wdata);
        wait_ready();
        user_addr = addr;
        rw        = wr;
        data_in   = wdata;
        in_valid  = 1'b1;
        if (wr) begin
            ref_mem[addr] = wdata;
        end else begin
            exp_q.push_back(expected_read(addr));
        end
        @(negedge clk);      // taken on the rising edge in between
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error("read responses missing after timeout");
            end
        end
    endtask

    // miss at base, then the rest of the burst from the buffer
    task automatic prefetch_run(input user_addr_t base);
        logic [31:0] reads_before;
        send(1'b0, base, '0);
        drain();
        reads_before = read_count;
        for (int i = 1; i < PREFETCH_DEPTH; i++) begin
            send(1'b0, {base[22:8], 8'(base[7:0] + i)}, '0);  // column wraps in the row
        end
        drain();
        check("READ count", read_count, reads_before);
    endtask

    task automatic invalidate_run(input user_addr_t base, input int k);
        logic [31:0] reads_before;
        user_addr_t  target;
        target = {base[22:8], 8'(base[7:0] + k)};
        send(1'b0, base, '0);
        drain();
        reads_before = read_count;
        send(1'b1, target, $urandom);
        send(1'b0, target, '0);
        drain();
        check("READ count", read_count, reads_before + PREFETCH_DEPTH);
    endtask

    initial begin
        int unsigned seed;
        user_addr_t  addr;
        row_t        row_pool [4];
        seed      = $urandom(SEED);
        rst       = 1'b1;
        in_valid  = 1'b0;
        user_addr = '0;
        rw        = 1'b0;
        data_in   = '0;

        repeat (4) begin
            @(negedge clk);
            check("busy", busy, 1'b1);
            check("out_valid", out_valid, 1'b0);
            check("pin command", {sdram_cs, sdram_ras, sdram_cas, sdram_we}, CMD_NOP);
            check("sdram_dq_oe", sdram_dq_oe, 1'b0);
            check("sdram_cle", sdram_cle, 1'b0);
        end
        rst = 1'b0;
        @(negedge clk);
        check("sdram_cle", sdram_cle, 1'b1);
        wait_ready();

        for (int n = 0; n < 24; n++) begin
            addr = user_addr_t'($urandom);
            send(1'b1, addr, $urandom);
            send(1'b0, addr, '0);
        end
        for (int n = 0; n < 10; n++) begin
            do begin
                addr = user_addr_t'($urandom);
            end while (ref_mem.exists(addr));
            send(1'b0, addr, '0);
        end
        drain();

        for (int n = 0; n < 4; n++) begin
            prefetch_run(user_addr_t'($urandom));
        end
        prefetch_run({row_t'($urandom), bank_t'($urandom), 8'hfc});
        for (int n = 0; n < 4; n++) begin
            invalidate_run(user_addr_t'($urandom), 1 + $urandom % 7);
        end

        // small address pool so hits, misses and row changes all occur
        foreach (row_pool[i]) begin
            row_pool[i] = row_t'($urandom);
        end
        for (int n = 0; n < 400; n++) begin
            addr = {row_pool[$urandom % 4], bank_t'($urandom), 8'($urandom % 24)};
            if ($urandom % 10 < 4) begin
                send(1'b1, addr, $urandom);
            end else begin
                send(1'b0, addr, '0);
            end
        end
        drain();
        check("REFRESH seen", refresh_seen > 0, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/sdram_ctrl_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_sva import sdram_pkg::*; #(
    parameter int T_RCD = 3,
    parameter int T_RP  = 3,
    parameter int T_RFC = 7
) (
    input wire clk,
    input wire rst,
    input wire out_valid,
    input wire sdram_cs,
    input wire sdram_ras,
    input wire sdram_cas,
    input wire sdram_we,
    input wire sdram_dq_oe
);

    logic [3:0]  pin_cmd;
    int unsigned fail_count = 0;

    assign pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    ////////////////////////////////////////////////////////////
    // command gaps on the pins
    ////////////////////////////////////////////////////////////

    a_rcd_gap: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd == CMD_ACTIVE) |=> (pin_cmd == CMD_NOP) [*T_RCD])
        else begin
            fail_count++;
            $error("command inside the activate gap");
        end

    a_rp_gap: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd == CMD_PRECHARGE) |=> (pin_cmd == CMD_NOP) [*T_RP])
        else begin
            fail_count++;
            $error("command inside the precharge gap");
        end

    a_rfc_gap: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd == CMD_REFRESH) |=> (pin_cmd == CMD_NOP) [*T_RFC])
        else begin
            fail_count++;
            $error("command inside the refresh gap");
        end

    // data bus driven only with the WRITE itself
    a_dq_oe: assert property (@(posedge clk) disable iff (rst)
        sdram_dq_oe |-> (pin_cmd == CMD_WRITE))
        else begin
            fail_count++;
            $error("sdram_dq_oe high without a WRITE");
        end

    a_reset_out: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

endmodule

bind sdram_ctrl_top sdram_ctrl_sva #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RFC (T_RFC)
) u_sva (
    .clk         (clk),
    .rst         (rst),
    .out_valid   (out_valid),
    .sdram_cs    (sdram_cs),
    .sdram_ras   (sdram_ras),
    .sdram_cas   (sdram_cas),
    .sdram_we    (sdram_we),
    .sdram_dq_oe (sdram_dq_oe)
);

`default_nettype wire

/* bench/sdram_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_mem_model import sdram_pkg::*; #(
    parameter int T_CAS = 3
) (
    input  wire         clk,
    input  wire         cs,
    input  wire         ras,
    input  wire         cas,
    input  wire         we,
    input  wire bank_t  ba,
    input  wire [12:0]  a,
    input  wire word_t  dqo,
    input  wire         dq_oe,
    output word_t       dqi,
    output logic [31:0] read_count
);

    word_t       mem [user_addr_t];     // keyed like a user address
    row_t        open_rows [NUM_BANKS];
    word_t       rd_pipe [T_CAS] = '{default: '0};
    logic [3:0]  cmd;
    user_addr_t  addr;
    int unsigned reads = 0;

    assign cmd        = {cs, ras, cas, we};
    assign addr       = {open_rows[ba], ba, a[9:2]};
    assign dqi        = rd_pipe[T_CAS-1];  // CAS latency after the READ edge
    assign read_count = reads;

    always @(posedge clk) begin
        rd_pipe[0] <= '0;
        for (int i = 1; i < T_CAS; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        case (cmd)
            CMD_ACTIVE: open_rows[ba] <= a;
            CMD_WRITE: begin
                if (dq_oe) begin
                    mem[addr] = dqo;
                end
            end
            CMD_READ: begin
                // words never written come back as their own address
                rd_pipe[0] <= mem.exists(addr) ? mem[addr] : word_t'(addr);
                reads <= reads + 1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/sdram_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_top import sdram_pkg::*; #(
    parameter int T_CAS            = 3,
    parameter int T_RCD            = 3,
    parameter int T_RP             = 3,
    parameter int T_RFC            = 7,
    parameter int REFRESH_INTERVAL = 750,
    parameter int PREFETCH_DEPTH   = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire user_addr_t user_addr,
    input  wire             rw,          // 1 = write
    input  wire word_t      data_in,
    input  wire             in_valid,
    output word_t           data_out,
    output logic            busy,
    output logic            out_valid,
    output logic            sdram_cle,
    output logic            sdram_cs,
    output logic            sdram_ras,
    output logic            sdram_cas,
    output logic            sdram_we,
    output bank_t           sdram_ba,
    output logic [12:0]     sdram_a,
    input  wire word_t      sdram_dqi,
    output word_t           sdram_dqo,
    output logic            sdram_dq_oe
);

    logic       refresh_req;
    logic       refresh_ack;
    user_addr_t query_addr;
    logic       open_row;
    bank_t      close_bank;
    logic       close_all;
    logic       do_close;
    logic       row_open;
    logic       row_hit;
    word_t      dqi_q;

    prefetch_if pf_bus ();
    cmd_if      cmd_bus ();

    sdram_cmd_seq #(
        .T_RCD          (T_RCD),
        .T_RP           (T_RP),
        .T_RFC          (T_RFC),
        .PREFETCH_DEPTH (PREFETCH_DEPTH)
    ) u_seq (
        .clk         (clk),
        .rst         (rst),
        .user_addr   (user_addr),
        .rw          (rw),
        .data_in     (data_in),
        .in_valid    (in_valid),
        .refresh_req (refresh_req),
        .row_open    (row_open),
        .row_hit     (row_hit),
        .busy        (busy),
        .out_valid   (out_valid),
        .data_out    (data_out),
        .refresh_ack (refresh_ack),
        .query_addr  (query_addr),
        .open_row    (open_row),
        .close_bank  (close_bank),
        .close_all   (close_all),
        .do_close    (do_close),
        .pf          (pf_bus.sequencer),
        .cmd         (cmd_bus.source)
    );

    bank_row_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .query_addr (query_addr),
        .open_row   (open_row),
        .close_bank (close_bank),
        .close_all  (close_all),
        .do_close   (do_close),
        .row_open   (row_open),
        .row_hit    (row_hit)
    );

    refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_refresh (
        .clk         (clk),
        .rst         (rst),
        .refresh_ack (refresh_ack),
        .refresh_req (refresh_req)
    );

    prefetch_buffer #(.T_CAS(T_CAS), .PREFETCH_DEPTH(PREFETCH_DEPTH)) u_prefetch (
        .clk   (clk),
        .rst   (rst),
        .dqi_q (dqi_q),
        .pf    (pf_bus.buffer)
    );

    sdram_pins u_pins (
        .clk         (clk),
        .rst         (rst),
        .sdram_dqi   (sdram_dqi),
        .cmd         (cmd_bus.sink),
        .dqi_q       (dqi_q),
        .sdram_cle   (sdram_cle),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

endmodule

`default_nettype wire

/* verilog/sdram_cmd_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_cmd_seq import sdram_pkg::*; #(
    parameter int T_RCD          = 3,
    parameter int T_RP           = 3,
    parameter int T_RFC          = 7,
    parameter int PREFETCH_DEPTH = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire user_addr_t user_addr,
    input  wire             rw,
    input  wire word_t      data_in,
    input  wire             in_valid,
    input  wire             refresh_req,
    input  wire             row_open,
    input  wire             row_hit,
    output logic            busy,
    output logic            out_valid,
    output word_t           data_out,
    output logic            refresh_ack,
    output user_addr_t      query_addr,
    output logic            open_row,
    output bank_t           close_bank,
    output logic            close_all,
    output logic            do_close,
    prefetch_if.sequencer   pf,
    cmd_if.source           cmd
);

    localparam int BW = $clog2(PREFETCH_DEPTH + 1);

    seq_state_e    state;
    seq_state_e    next_state;  // target of WAIT
    logic [7:0]    wait_cnt;
    logic [BW-1:0] burst_cnt;
    logic          up;
    logic          q_valid;
    user_addr_t    q_addr;
    logic          q_rw;
    word_t         q_data;
    user_addr_t    addr_q;      // request in service
    logic          rw_q;
    word_t         wdata_q;
    logic          pre_all;
    logic          resp_pend;
    word_t         resp_word;
    logic          take;
    col_t          burst_col;

    assign busy        = q_valid | ~up;
    assign take        = (state == IDLE) && !refresh_req && q_valid;
    assign refresh_ack = (state == IDLE) && refresh_req;   // refresh wins over the queue
    assign query_addr  = (state == IDLE) ? q_addr : addr_q;
    assign burst_col   = addr_col(addr_q) + col_t'(burst_cnt);  // wraps inside the row

    assign pf.lookup_addr = q_addr;

    ////////////////////////////////////////////////////////////
    // command bus and side strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        cmd.cmd        = CMD_NOP;
        cmd.ba         = addr_bank(addr_q);
        cmd.a          = '0;
        cmd.wdata      = wdata_q;
        cmd.wen        = 1'b0;
        open_row       = 1'b0;
        do_close       = 1'b0;
        close_all      = pre_all;
        close_bank     = addr_bank(addr_q);
        pf.fill_start  = 1'b0;
        pf.issue_valid = 1'b0;
        pf.issue_addr  = {addr_row(addr_q), addr_bank(addr_q), burst_col};
        pf.wr_valid    = 1'b0;
        pf.wr_addr     = addr_q;
        case (state)
            ACTIVATE: begin
                cmd.cmd  = CMD_ACTIVE;
                cmd.a    = addr_row(addr_q);
                open_row = 1'b1;
            end
            PRECHARGE: begin
                cmd.cmd   = CMD_PRECHARGE;
                cmd.a[10] = pre_all;   // all banks
                do_close  = 1'b1;
            end
            REFRESH: cmd.cmd = CMD_REFRESH;
            WRITE: begin
                cmd.cmd     = CMD_WRITE;
                cmd.a       = {3'b000, addr_col(addr_q), 2'b00};
                cmd.wen     = 1'b1;
                pf.wr_valid = 1'b1;    // drop a stale copy from the buffer
            end
            READ_BURST: begin
                if (burst_cnt < PREFETCH_DEPTH) begin
                    cmd.cmd        = CMD_READ;
                    cmd.a          = {3'b000, burst_col, 2'b00};
                    pf.issue_valid = 1'b1;
                    pf.fill_start  = (burst_cnt == '0);
                end
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state machine and queue control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            next_state <= IDLE;
            wait_cnt   <= '0;
            burst_cnt  <= '0;
            up         <= 1'b0;
            q_valid    <= 1'b0;
            pre_all    <= 1'b0;
            resp_pend  <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            up        <= 1'b1;
            out_valid <= resp_pend;
            resp_pend <= 1'b0;
            if (!busy && in_valid) begin
                q_valid <= 1'b1;
            end else if (take) begin
                q_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (refresh_req) begin
                        pre_all    <= 1'b1;
                        next_state <= REFRESH;
                        state      <= PRECHARGE;
                    end else if (q_valid) begin
                        if (!q_rw && pf.hit) begin
                            resp_pend <= 1'b1;        // answered from the buffer
                        end else if (row_hit) begin
                            state <= q_rw ? WRITE : READ_BURST;
                        end else if (row_open) begin
                            pre_all    <= 1'b0;       // other row open in this bank
                            next_state <= ACTIVATE;
                            state      <= PRECHARGE;
                        end else begin
                            state <= ACTIVATE;
                        end
                    end
                end
                PRECHARGE: begin
                    wait_cnt <= 8'(T_RP - 1);
                    state    <= WAIT;
                end
                ACTIVATE: begin
                    wait_cnt   <= 8'(T_RCD - 1);
                    next_state <= rw_q ? WRITE : READ_BURST;
                    state      <= WAIT;
                end
                REFRESH: begin
                    wait_cnt   <= 8'(T_RFC - 1);
                    next_state <= IDLE;
                    state      <= WAIT;
                end
                WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= next_state;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                WRITE: state <= IDLE;
                READ_BURST: begin
                    if (burst_cnt < PREFETCH_DEPTH) begin
                        burst_cnt <= burst_cnt + 1'b1;
                    end else if (pf.fill_done) begin
                        burst_cnt <= '0;
                        resp_pend <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request payload and response data
    always_ff @(posedge clk) begin
        if (!busy && in_valid) begin
            q_addr <= user_addr;
            q_rw   <= rw;
            q_data <= data_in;
        end
        if (take) begin
            addr_q    <= q_addr;
            rw_q      <= q_rw;
            wdata_q   <= q_data;
            resp_word <= pf.hit_data;
        end else if (state == READ_BURST && pf.fill_done) begin
            resp_word <= pf.fill_data;
        end
        if (resp_pend) begin
            data_out <= resp_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/sdram_pins.sv */
`timescale 1ns/1ns
`default_nettype none

module sdram_pins import sdram_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire word_t  sdram_dqi,
    cmd_if.sink         cmd,
    output word_t       dqi_q,
    output logic        sdram_cle,
    output logic        sdram_cs,
    output logic        sdram_ras,
    output logic        sdram_cas,
    output logic        sdram_we,
    output bank_t       sdram_ba,
    output logic [12:0] sdram_a,
    output word_t       sdram_dqo,
    output logic        sdram_dq_oe
);

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_cle <= 1'b0;
            {sdram_cs, sdram_ras, sdram_cas, sdram_we} <= CMD_NOP;
            sdram_dq_oe <= 1'b0;
        end else begin
            sdram_cle <= 1'b1;
            {sdram_cs, sdram_ras, sdram_cas, sdram_we} <= cmd.cmd;
            sdram_dq_oe <= cmd.wen;   // only with the WRITE itself
        end
    end

    always_ff @(posedge clk) begin
        sdram_ba  <= cmd.ba;
        sdram_a   <= cmd.a;
        sdram_dqo <= cmd.wdata;
        dqi_q     <= sdram_dqi;       // capture stage for the buffer
    end

endmodule

`default_nettype wire

/* verilog/prefetch_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer import sdram_pkg::*; #(
    parameter int T_CAS          = 3,
    parameter int PREFETCH_DEPTH = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire word_t dqi_q,
    prefetch_if.buffer pf
);

    // issue -> pin register -> CAS latency -> capture register
    localparam int DLY = T_CAS + 2;
    localparam int PW  = $clog2(PREFETCH_DEPTH);

    logic [DLY-1:0]            dly_v;
    user_addr_t                dly_a [DLY];
    user_addr_t                tags [PREFETCH_DEPTH];
    word_t                     data [PREFETCH_DEPTH];
    logic [PREFETCH_DEPTH-1:0] valid;
    logic [PW-1:0]             wr_ptr;
    logic                      land;

    assign land         = dly_v[DLY-1];  // dqi_q holds the word of dly_a[DLY-1]
    assign pf.fill_data = data[0];

    ////////////////////////////////////////////////////////////
    // fill pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dly_v <= '0;
        end else begin
            dly_v <= {dly_v[DLY-2:0], pf.issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        dly_a[0] <= pf.issue_addr;
        for (int i = 1; i < DLY; i++) begin
            dly_a[i] <= dly_a[i-1];
        end
        if (land) begin
            tags[wr_ptr] <= dly_a[DLY-1];
            data[wr_ptr] <= dqi_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid        <= '0;
            wr_ptr       <= '0;
            pf.fill_done <= 1'b0;
        end else begin
            pf.fill_done <= land && (wr_ptr == PW'(PREFETCH_DEPTH - 1));
            if (pf.fill_start) begin
                valid  <= '0;
                wr_ptr <= '0;
            end else if (land) begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            if (pf.wr_valid) begin
                for (int i = 0; i < PREFETCH_DEPTH; i++) begin
                    if (valid[i] && tags[i] == pf.wr_addr) begin
                        valid[i] <= 1'b0;   // write hit
                    end
                end
            end
        end
    end

    // parallel tag compare, tags are unique within a fill
    always_comb begin
        pf.hit      = 1'b0;
        pf.hit_data = '0;
        for (int i = 0; i < PREFETCH_DEPTH; i++) begin
            if (valid[i] && tags[i] == pf.lookup_addr) begin
                pf.hit      = 1'b1;
                pf.hit_data = data[i];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/bank_row_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_row_tracker import sdram_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire user_addr_t query_addr,
    input  wire             open_row,    // ACTIVATE for the queried bank
    input  wire bank_t      close_bank,
    input  wire             close_all,
    input  wire             do_close,
    output logic            row_open,
    output logic            row_hit
);

    logic [NUM_BANKS-1:0] bank_open;
    row_t                 open_rows [NUM_BANKS];
    bank_t                q_bank;

    assign q_bank   = addr_bank(query_addr);
    assign row_open = bank_open[q_bank];
    assign row_hit  = row_open && (open_rows[q_bank] == addr_row(query_addr));

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_open <= '0;
        end else if (do_close) begin
            if (close_all) begin
                bank_open <= '0;
            end else begin
                bank_open[close_bank] <= 1'b0;
            end
        end else if (open_row) begin
            bank_open[q_bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (open_row) begin
            open_rows[q_bank] <= addr_row(query_addr);
        end
    end

endmodule

`default_nettype wire

/* verilog/refresh_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module refresh_timer #(
    parameter int REFRESH_INTERVAL = 750
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  refresh_ack,
    output logic refresh_req
);

    localparam int CW = $clog2(REFRESH_INTERVAL);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            refresh_req <= 1'b0;
        end else begin
            if (refresh_ack) begin
                refresh_req <= 1'b0;
            end
            if (cnt == CW'(REFRESH_INTERVAL - 1)) begin
                cnt         <= '0;
                refresh_req <= 1'b1;   // held until the sequencer takes it
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sdram_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

// sequencer <-> prefetch buffer
interface prefetch_if import sdram_pkg::*; ();
    user_addr_t lookup_addr;
    logic       hit;
    word_t      hit_data;
    logic       fill_start;   // clears the buffer, first READ of a burst
    logic       issue_valid;  // one per READ command
    user_addr_t issue_addr;
    logic       fill_done;    // last word of the burst landed
    word_t      fill_data;    // word of the requested address
    logic       wr_valid;
    user_addr_t wr_addr;

    modport sequencer (
        output lookup_addr, fill_start, issue_valid, issue_addr, wr_valid, wr_addr,
        input  hit, hit_data, fill_done, fill_data
    );
    modport buffer (
        input  lookup_addr, fill_start, issue_valid, issue_addr, wr_valid, wr_addr,
        output hit, hit_data, fill_done, fill_data
    );
endinterface

// sequencer -> pin registers, one cycle ahead of the pins
interface cmd_if import sdram_pkg::*; ();
    sdram_cmd_e  cmd;
    bank_t       ba;
    logic [12:0] a;
    word_t       wdata;
    logic        wen;

    modport source (output cmd, ba, a, wdata, wen);
    modport sink   (input cmd, ba, a, wdata, wen);
endinterface

`default_nettype wire

/* verilog/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

    ////////////////////////////////////////////////////////////
    // widths and address fields
    ////////////////////////////////////////////////////////////

    localparam int NUM_BANKS = 4;

    typedef logic [22:0] user_addr_t;  // row 22:10, bank 9:8, col 7:0
    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [7:0]  col_t;
    typedef logic [31:0] word_t;

    function automatic row_t addr_row(user_addr_t addr);
        return addr[22:10];
    endfunction

    function automatic bank_t addr_bank(user_addr_t addr);
        return addr[9:8];
    endfunction

    function automatic col_t addr_col(user_addr_t addr);
        return addr[7:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // command encoding {cs, ras, cas, we}
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        REFRESH,
        ACTIVATE,
        READ_BURST,
        WRITE,
        PRECHARGE,
        WAIT
    } seq_state_e;

endpackage

`default_nettype wire
